//--- hw/axi_bridge_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, window map, response codes and watchdog limit
// FSM state type for the AXI access engine
//////////////////////////////////////////////////////////////////////

package axi_bridge_pkg;

   ///////////////////////////////////////////////////////////////////
   // bus and AXI field widths
   ///////////////////////////////////////////////////////////////////
   localparam int unsigned data_w = 32;
   localparam int unsigned addr_w = 32;
   localparam int unsigned id_w   = 4;
   localparam int unsigned len_w  = 8;   // AXI4 AxLEN
   localparam int unsigned size_w = 3;   // AxSIZE

   // response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   localparam logic [size_w-1:0] size_word = 3'd2;  // 4 bytes, the only legal size

   // watchdog
   localparam int unsigned timeout_cycles = 32;
   localparam int unsigned wd_cnt_w       = 6;

   ///////////////////////////////////////////////////////////////////
   // register map, three windows of 0x100 bytes
   ///////////////////////////////////////////////////////////////////
   localparam logic [addr_w-1:0] fast_base = 32'h0000_0000;
   localparam logic [addr_w-1:0] slow_base = 32'h0000_0100;
   localparam logic [addr_w-1:0] hole_base = 32'h0000_0200;  // unmapped from here up
   localparam int unsigned win_bytes  = 'h100;
   localparam int unsigned fast_words = 16;
   localparam int unsigned slow_words = 16;
   localparam int unsigned slow_delay = 6;   // strobe to ack, slow window
   localparam int unsigned slow_cnt_w = 3;

   // one access at a time, write first
   typedef enum logic [2:0] {
      st_idle,
      st_wr_data,
      st_wr_bus,
      st_rd_bus,
      st_wr_resp,
      st_rd_resp
   } access_state_t;

endpackage

//--- hw/sys_bus_if.sv
//////////////////////////////////////////////////////////////////////
// simple system bus, one-cycle strobes and one-cycle acknowledge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface sys_bus_if
   import axi_bridge_pkg::*;
();

   logic [addr_w-1:0] addr;   // held for the whole access
   logic [data_w-1:0] wdata;
   logic              wen;    // write strobe, one cycle
   logic              ren;    // read strobe, one cycle
   logic [data_w-1:0] rdata;  // valid with ack
   logic              ack;

   // bridge side
   modport m (
      output addr, wdata, wen, ren,
      input  rdata, ack
   );

   // register block side
   modport s (
      input  addr, wdata, wen, ren,
      output rdata, ack
   );

endinterface

//--- hw/ack_watchdog.sv
//////////////////////////////////////////////////////////////////////
// acknowledge watchdog for a pending bus access
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ack_watchdog
   import axi_bridge_pkg::*;
(
   input  logic axi,
   input  logic rst_n,
   input  logic start,     // access accepted
   input  logic stop,      // ack or response seen
   output logic timeout    // one-cycle pulse
);

   logic [wd_cnt_w-1:0] cnt;   // zero means idle
   logic                limit;

   // last counting step before the limit
   assign limit = (cnt == wd_cnt_w'(timeout_cycles - 1));

   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n) begin
         cnt     <= '0;
         timeout <= 1'b0;
      end else begin
         timeout <= 1'b0;
         if (start) begin
            cnt <= wd_cnt_w'(1);       // restart beats a stale count
         end else if (stop) begin
            cnt <= '0;
         end else if (limit) begin
            cnt     <= '0;             // self clear, FSM decides the rest
            timeout <= 1'b1;
         end else if (cnt != '0) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

//--- hw/reg_bank.sv
//////////////////////////////////////////////////////////////////////
// register block behind the system bus
// fast register file, slow scratch memory, unmapped hole
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module reg_bank
   import axi_bridge_pkg::*;
(
   input  logic axi,
   input  logic rst_n,
   sys_bus_if.s bus
);

   logic [data_w-1:0] fast_regs [fast_words];
   logic [data_w-1:0] slow_mem  [slow_words];

   logic [$clog2(fast_words)-1:0] fast_idx;
   logic [$clog2(slow_words)-1:0] slow_idx;
   logic                          fast_hit;
   logic                          slow_hit;
   logic                          strobe;

   logic                  fast_ack;
   logic                  slow_ack;
   logic [slow_cnt_w-1:0] slow_cnt;   // zero when no slow access open
   logic [data_w-1:0]     rd_q;

   ///////////////////////////////////////////////////////////////////
   // address decode
   ///////////////////////////////////////////////////////////////////
   assign strobe   = bus.wen || bus.ren;
   assign fast_hit = (bus.addr < (fast_base + win_bytes));
   assign slow_hit = (bus.addr >= slow_base) && (bus.addr < hole_base);
   // anything from hole_base up is left alone, no ack ever

   // word index inside a window
   assign fast_idx = bus.addr[2 +: $clog2(fast_words)];
   assign slow_idx = bus.addr[2 +: $clog2(slow_words)];

   ///////////////////////////////////////////////////////////////////
   // fast window
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < fast_words; i++)
            fast_regs[i] <= '0;
      end else if (bus.wen && fast_hit) begin
         fast_regs[fast_idx] <= bus.wdata;    // full word, no strobes
      end
   end

   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n)
         fast_ack <= 1'b0;
      else
         fast_ack <= strobe && fast_hit;      // ack next cycle
   end

   ///////////////////////////////////////////////////////////////////
   // slow window
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge axi) begin
      if (bus.wen && slow_hit)
         slow_mem[slow_idx] <= bus.wdata;
   end

   // delay counter, ack lands slow_delay cycles after the strobe
   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n) begin
         slow_cnt <= '0;
         slow_ack <= 1'b0;
      end else begin
         slow_ack <= 1'b0;
         if (strobe && slow_hit) begin
            slow_cnt <= slow_cnt_w'(slow_delay - 1);
         end else if (slow_cnt == slow_cnt_w'(1)) begin
            slow_cnt <= '0;
            slow_ack <= 1'b1;
         end else if (slow_cnt != '0) begin
            slow_cnt <= slow_cnt - 1'b1;
         end
      end
   end

   ///////////////////////////////////////////////////////////////////
   // read data, captured when the ack is raised
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge axi) begin
      if (bus.ren && fast_hit)
         rd_q <= fast_regs[fast_idx];
      else if (slow_cnt == slow_cnt_w'(1))
         rd_q <= slow_mem[slow_idx];          // address still held by bridge
   end

   assign bus.ack   = fast_ack || slow_ack;
   assign bus.rdata = rd_q;

endmodule

//--- hw/axi_access_fsm.sv
//////////////////////////////////////////////////////////////////////
// AXI4 slave channel FSM, single beat, write before read
// legality check, request latching, bus strobes, B and R responses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module axi_access_fsm
   import axi_bridge_pkg::*;
(
   input  logic              axi,
   input  logic              rst_n,
   // write address
   input  logic              awvalid,
   output logic              awready,
   input  logic [addr_w-1:0] awaddr,
   input  logic [id_w-1:0]   awid,
   input  logic [len_w-1:0]  awlen,
   input  logic [size_w-1:0] awsize,
   // write data
   input  logic              wvalid,
   output logic              wready,
   input  logic [data_w-1:0] wdata,
   // write response
   output logic              bvalid,
   input  logic              bready,
   output logic [id_w-1:0]   bid,
   output logic [1:0]        bresp,
   // read address
   input  logic              arvalid,
   output logic              arready,
   input  logic [addr_w-1:0] araddr,
   input  logic [id_w-1:0]   arid,
   input  logic [len_w-1:0]  arlen,
   input  logic [size_w-1:0] arsize,
   // read data
   output logic              rvalid,
   input  logic              rready,
   output logic [id_w-1:0]   rid,
   output logic [data_w-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rlast,
   // system bus and watchdog
   sys_bus_if.m              bus,
   output logic              wd_start,
   output logic              wd_stop,
   input  logic              wd_timeout
);

   access_state_t     state;
   logic [id_w-1:0]   acc_id;     // shared, only one access open
   logic [addr_w-1:0] acc_addr;
   logic [data_w-1:0] acc_wdata;
   logic              acc_err;    // write request was illegal
   logic              resp_err;   // selects SLVERR on B or R
   logic              ren_pend;   // delays ren by one cycle

   logic aw_hs, w_hs, ar_hs, b_hs, r_hs;
   logic aw_bad, ar_bad;
   logic on_bus, bus_done;

   ///////////////////////////////////////////////////////////////////
   // handshakes and legality
   ///////////////////////////////////////////////////////////////////
   assign awready = (state == st_idle);
   assign arready = (state == st_idle) && !awvalid;   // writes win
   assign wready  = (state == st_wr_data);

   assign aw_hs = awvalid && awready;
   assign ar_hs = arvalid && arready;
   assign w_hs  = wvalid && wready;
   assign b_hs  = bvalid && bready;
   assign r_hs  = rvalid && rready;

   // no bursts, word size only
   assign aw_bad = (awlen != '0) || (awsize != size_word);
   assign ar_bad = (arlen != '0) || (arsize != size_word);

   assign on_bus   = (state == st_wr_bus) || (state == st_rd_bus);
   assign bus_done = on_bus && (bus.ack || wd_timeout);  // ack wins a tie

   assign wd_start = aw_hs || ar_hs;
   assign wd_stop  = (on_bus && bus.ack) || b_hs || r_hs;

   ///////////////////////////////////////////////////////////////////
   // control and strobes
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         acc_err  <= 1'b0;
         resp_err <= 1'b0;
         ren_pend <= 1'b0;
         bvalid   <= 1'b0;
         rvalid   <= 1'b0;
         rlast    <= 1'b0;
         bus.wen  <= 1'b0;
         bus.ren  <= 1'b0;
      end else begin
         bus.wen  <= w_hs && !acc_err;       // same edge as data capture
         ren_pend <= ar_hs && !ar_bad;
         bus.ren  <= ren_pend;               // cycle after AR
         unique case (state)
            st_idle: begin
               if (aw_hs) begin
                  acc_err <= aw_bad;
                  state   <= st_wr_data;
               end else if (ar_hs && ar_bad) begin
                  resp_err <= 1'b1;          // refused, bus untouched
                  rvalid   <= 1'b1;
                  rlast    <= 1'b1;
                  state    <= st_rd_resp;
               end else if (ar_hs) begin
                  state <= st_rd_bus;
               end
            end
            st_wr_data: begin
               if (w_hs && acc_err) begin
                  resp_err <= 1'b1;
                  bvalid   <= 1'b1;
                  state    <= st_wr_resp;
               end else if (w_hs) begin
                  state <= st_wr_bus;
               end
            end
            st_wr_bus: begin
               if (bus_done) begin
                  resp_err <= !bus.ack;      // timeout
                  bvalid   <= 1'b1;
                  state    <= st_wr_resp;
               end
            end
            st_rd_bus: begin
               if (bus_done) begin
                  resp_err <= !bus.ack;
                  rvalid   <= 1'b1;
                  rlast    <= 1'b1;
                  state    <= st_rd_resp;
               end
            end
            st_wr_resp: begin
               if (bready) begin
                  bvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            st_rd_resp: begin
               if (rready) begin
                  rvalid <= 1'b0;
                  rlast  <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   ///////////////////////////////////////////////////////////////////
   // request and read data capture
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge axi) begin
      if (aw_hs) begin
         acc_id   <= awid;
         acc_addr <= awaddr;
      end else if (ar_hs) begin
         acc_id   <= arid;
         acc_addr <= araddr;
      end
      if (w_hs)
         acc_wdata <= wdata;
      if ((state == st_rd_bus) && bus.ack)
         rdata <= bus.rdata;
      else if ((ar_hs && ar_bad) || ((state == st_rd_bus) && wd_timeout))
         rdata <= '0;                        // zero on any read error
   end

   assign bid   = acc_id;
   assign rid   = acc_id;
   assign bresp = resp_err ? resp_slverr : resp_okay;
   assign rresp = resp_err ? resp_slverr : resp_okay;

   assign bus.addr  = acc_addr;
   assign bus.wdata = acc_wdata;

endmodule

//--- hw/axi_bridge_top.sv
//////////////////////////////////////////////////////////////////////
// AXI4 slave bridge top, FSM + watchdog + register block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module axi_bridge_top
   import axi_bridge_pkg::*;
(
   input  logic              axi,
   input  logic              rst_n,
   // AW
   input  logic              awvalid,
   output logic              awready,
   input  logic [addr_w-1:0] awaddr,
   input  logic [id_w-1:0]   awid,
   input  logic [len_w-1:0]  awlen,
   input  logic [size_w-1:0] awsize,
   // W
   input  logic              wvalid,
   output logic              wready,
   input  logic [data_w-1:0] wdata,
   // B
   output logic              bvalid,
   input  logic              bready,
   output logic [id_w-1:0]   bid,
   output logic [1:0]        bresp,
   // AR
   input  logic              arvalid,
   output logic              arready,
   input  logic [addr_w-1:0] araddr,
   input  logic [id_w-1:0]   arid,
   input  logic [len_w-1:0]  arlen,
   input  logic [size_w-1:0] arsize,
   // R
   output logic              rvalid,
   input  logic              rready,
   output logic [id_w-1:0]   rid,
   output logic [data_w-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rlast
);

   sys_bus_if bus_if ();

   logic wd_start;
   logic wd_stop;
   logic wd_timeout;

   axi_access_fsm u_fsm (
      .axi, .rst_n,
      .awvalid, .awready, .awaddr, .awid, .awlen, .awsize,
      .wvalid, .wready, .wdata,
      .bvalid, .bready, .bid, .bresp,
      .arvalid, .arready, .araddr, .arid, .arlen, .arsize,
      .rvalid, .rready, .rid, .rdata, .rresp, .rlast,
      .bus        (bus_if.m),
      .wd_start   (wd_start),
      .wd_stop    (wd_stop),
      .wd_timeout (wd_timeout)
   );

   // guards against the unmapped window
   ack_watchdog u_wd (
      .axi, .rst_n,
      .start   (wd_start),
      .stop    (wd_stop),
      .timeout (wd_timeout)
   );

   reg_bank u_regs (
      .axi, .rst_n,
      .bus (bus_if.s)
   );

endmodule

//--- bench/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// testbench clock source, 4 ns period
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock (
   output logic axi
);

   initial axi = 1'b0;

   always #2 axi = ~axi;   // half period 2 ns

endmodule

//--- bench/axi_bridge_asserts.sv
//////////////////////////////////////////////////////////////////////
// protocol and response assertions for the AXI access FSM
// bound into every axi_access_fsm instance
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module axi_bridge_asserts
   import axi_bridge_pkg::*;
(
   input logic              axi,
   input logic              rst_n,
   input logic              awvalid,
   input logic              awready,
   input logic [len_w-1:0]  awlen,
   input logic [size_w-1:0] awsize,
   input logic              arvalid,
   input logic              arready,
   input logic [len_w-1:0]  arlen,
   input logic [size_w-1:0] arsize,
   input logic              bvalid,
   input logic              bready,
   input logic [id_w-1:0]   bid,
   input logic [1:0]        bresp,
   input logic              rvalid,
   input logic              rready,
   input logic [id_w-1:0]   rid,
   input logic [data_w-1:0] rdata,
   input logic [1:0]        rresp,
   input logic              rlast,
   input logic              wen,
   input logic              ren
);

   // one sticky flag per assertion
   logic f_excl     = 1'b0;
   logic f_hold_b   = 1'b0;
   logic f_hold_r   = 1'b0;
   logic f_refused  = 1'b0;
   logic f_err_data = 1'b0;
   logic f_quiet    = 1'b0;
   logic f_bound    = 1'b0;
   logic failed;

   logic       aw_hs, ar_hs, b_hs, r_hs;
   logic       aw_bad, ar_bad;   // burst or non-word size
   logic       acc_open;   // accepted, response not yet taken
   logic       bad_open;   // refused access still open
   logic       timing;     // acceptance seen, no response yet
   logic [7:0] lat;        // cycles since acceptance

   assign failed = f_excl | f_hold_b | f_hold_r | f_refused
                 | f_err_data | f_quiet | f_bound;

   //////////////////////////////////////////////////////////////////
   // helper state
   //////////////////////////////////////////////////////////////////
   assign aw_hs = awvalid && awready;
   assign ar_hs = arvalid && arready;
   assign b_hs  = bvalid && bready;
   assign r_hs  = rvalid && rready;

   // single beat of 4 bytes only
   assign aw_bad = (awlen != '0) || (awsize != size_word);
   assign ar_bad = (arlen != '0) || (arsize != size_word);

   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n) begin
         acc_open <= 1'b0;
      end else if (aw_hs || ar_hs) begin
         acc_open <= 1'b1;
      end else if (b_hs || r_hs) begin
         acc_open <= 1'b0;
      end
   end

   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n) begin
         bad_open <= 1'b0;
      end else if ((aw_hs && aw_bad) || (ar_hs && ar_bad)) begin
         bad_open <= 1'b1;
      end else if (b_hs || r_hs) begin
         bad_open <= 1'b0;
      end
   end

   always_ff @(posedge axi or negedge rst_n) begin
      if (!rst_n) begin
         timing <= 1'b0;
         lat    <= '0;
      end else if (aw_hs || ar_hs) begin
         timing <= 1'b1;          // acceptance edge counts as 0
         lat    <= 8'd1;
      end else if (bvalid || rvalid) begin
         timing <= 1'b0;
      end else if (timing) begin
         lat <= lat + 8'd1;
      end
   end

   //////////////////////////////////////////////////////////////////
   // properties
   //////////////////////////////////////////////////////////////////
   // no second access while one is open, never both responses
   a_excl: assert property (@(posedge axi) disable iff (!rst_n)
      acc_open |-> (!awready && !arready && !(bvalid && rvalid)))
      else begin
         $error("address channel ready while an access is open");
         f_excl = 1'b1;
      end

   a_hold_b: assert property (@(posedge axi) disable iff (!rst_n)
      (bvalid && !bready) |=> (bvalid && $stable(bid) && $stable(bresp)))
      else begin
         $error("write response dropped or changed before bready");
         f_hold_b = 1'b1;
      end

   a_hold_r: assert property (@(posedge axi) disable iff (!rst_n)
      (rvalid && !rready) |=>
         (rvalid && rlast && $stable(rid) && $stable(rdata) && $stable(rresp)))
      else begin
         $error("read beat dropped or changed before rready");
         f_hold_r = 1'b1;
      end

   // refused burst or narrow access answers SLVERR
   a_refused: assert property (@(posedge axi) disable iff (!rst_n)
      bad_open |-> ((!bvalid || bresp == resp_slverr) &&
                    (!rvalid || rresp == resp_slverr)))
      else begin
         $error("refused access answered without SLVERR");
         f_refused = 1'b1;
      end

   a_err_data: assert property (@(posedge axi) disable iff (!rst_n)
      (rvalid && rresp == resp_slverr) |-> (rdata == '0))
      else begin
         $error("error read beat carries nonzero data");
         f_err_data = 1'b1;
      end

   a_quiet: assert property (@(posedge axi) disable iff (!rst_n)
      bad_open |-> !(wen || ren))
      else begin
         $error("refused access reached the system bus");
         f_quiet = 1'b1;
      end

   // watchdog limit plus two cycles of response latency
   a_bound: assert property (@(posedge axi) disable iff (!rst_n)
      timing |-> (lat <= 8'(timeout_cycles + 2)))
      else begin
         $error("no response within the watchdog bound");
         f_bound = 1'b1;
      end

endmodule

bind axi_access_fsm axi_bridge_asserts u_asserts (
   .axi      (axi),
   .rst_n    (rst_n),
   .awvalid  (awvalid),
   .awready  (awready),
   .awlen    (awlen),
   .awsize   (awsize),
   .arvalid  (arvalid),
   .arready  (arready),
   .arlen    (arlen),
   .arsize   (arsize),
   .bvalid   (bvalid),
   .bready   (bready),
   .bid      (bid),
   .bresp    (bresp),
   .rvalid   (rvalid),
   .rready   (rready),
   .rid      (rid),
   .rdata    (rdata),
   .rresp    (rresp),
   .rlast    (rlast),
   .wen      (bus.wen),
   .ren      (bus.ren)
);

//--- bench/tb_axi_bridge.sv
//////////////////////////////////////////////////////////////////////
// testbench top for the AXI bridge
// write and read tasks, model compare, run limit, final verdict
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_axi_bridge
   import axi_bridge_pkg::*;
();

   // 47 accesses, under 40 cycles each, plus margin
   localparam int unsigned max_cycles = 2000;

   logic              axi;
   logic              rst_n;
   logic              awvalid;
   logic              awready;
   logic [addr_w-1:0] awaddr;
   logic [id_w-1:0]   awid;
   logic [len_w-1:0]  awlen;
   logic [size_w-1:0] awsize;
   logic              wvalid;
   logic              wready;
   logic [data_w-1:0] wdata;
   logic              bvalid;
   logic              bready;
   logic [id_w-1:0]   bid;
   logic [1:0]        bresp;
   logic              arvalid;
   logic              arready;
   logic [addr_w-1:0] araddr;
   logic [id_w-1:0]   arid;
   logic [len_w-1:0]  arlen;
   logic [size_w-1:0] arsize;
   logic              rvalid;
   logic              rready;
   logic [id_w-1:0]   rid;
   logic [data_w-1:0] rdata;
   logic [1:0]        rresp;
   logic              rlast;

   logic [data_w-1:0] model [32];   // fast words 0..15, slow words 16..31
   int unsigned       cycles = 0;

   tb_clock u_clk (.axi(axi));

   axi_bridge_top UUT (.*);

   //////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////
   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_equal(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("MISMATCH %s expected %h actual %h", test, exp, act);
         abort_run();
      end
   endtask

   // model slot, window select bit plus word offset
   function automatic int unsigned word_idx(input logic [addr_w-1:0] addr);
      return {27'd0, addr[8], addr[5:2]};
   endfunction

   // single beat, word size and a mapped window, else SLVERR
   function automatic logic [1:0] expect_resp(input logic [addr_w-1:0] addr,
                                              input logic [len_w-1:0]  len,
                                              input logic [size_w-1:0] size);
      if (len != '0 || size != 3'd2 || addr >= 32'h200)
         return resp_slverr;
      return resp_okay;
   endfunction

   //////////////////////////////////////////////////////////////////
   // AXI master tasks
   //////////////////////////////////////////////////////////////////
   task automatic axi_write(input string test, input logic [addr_w-1:0] addr,
                            input logic [id_w-1:0] id, input logic [data_w-1:0] data,
                            input logic [len_w-1:0] len, input logic [size_w-1:0] size,
                            output int unsigned acc_cycle);
      int unsigned hold;
      logic [1:0]  exp;
      hold = $urandom % 4;                 // bready back-pressure
      exp  = expect_resp(addr, len, size);
      @(posedge axi);
      awvalid <= 1'b1;
      awaddr  <= addr;
      awid    <= id;
      awlen   <= len;
      awsize  <= size;
      wvalid  <= 1'b1;                     // data ready with the address
      wdata   <= data;
      @(posedge axi);
      while (!awready)
         @(posedge axi);
      acc_cycle = cycles;
      awvalid <= 1'b0;
      @(posedge axi);
      while (!wready)
         @(posedge axi);
      wvalid <= 1'b0;
      @(posedge axi);
      while (!bvalid)
         @(posedge axi);
      check_equal($sformatf("%s bresp", test), 32'(exp), 32'(bresp));
      check_equal($sformatf("%s bid", test), 32'(id), 32'(bid));
      if (exp == resp_okay)
         model[word_idx(addr)] = data;
      repeat (hold)
         @(posedge axi);
      bready <= 1'b1;
      @(posedge axi);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input string test, input logic [addr_w-1:0] addr,
                           input logic [id_w-1:0] id, input logic [len_w-1:0] len,
                           input logic [size_w-1:0] size, output int unsigned acc_cycle);
      int unsigned       hold;
      logic [1:0]        exp;
      logic [data_w-1:0] exp_data;
      hold = $urandom % 4;                 // rready back-pressure
      exp  = expect_resp(addr, len, size);
      @(posedge axi);
      arvalid <= 1'b1;
      araddr  <= addr;
      arid    <= id;
      arlen   <= len;
      arsize  <= size;
      @(posedge axi);
      while (!arready)
         @(posedge axi);
      acc_cycle = cycles;
      arvalid <= 1'b0;
      @(posedge axi);
      while (!rvalid)
         @(posedge axi);
      exp_data = (exp == resp_okay) ? model[word_idx(addr)] : '0;
      check_equal($sformatf("%s rresp", test), 32'(exp), 32'(rresp));
      check_equal($sformatf("%s rid", test), 32'(id), 32'(rid));
      check_equal($sformatf("%s rlast", test), 32'd1, 32'(rlast));
      check_equal($sformatf("%s rdata", test), exp_data, rdata);
      repeat (hold)
         @(posedge axi);
      rready <= 1'b1;
      @(posedge axi);
      rready <= 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////
   // run limit and assertion watch
   //////////////////////////////////////////////////////////////////
   always @(posedge axi) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("hang: run did not finish within %0d cycles", max_cycles);
         abort_run();
      end else if (UUT.u_fsm.u_asserts.failed) begin
         $display("a bound protocol assertion failed");
         abort_run();
      end
   end

   //////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////
   initial begin
      int unsigned       t_aw;
      int unsigned       t_ar;
      logic [data_w-1:0] val;
      void'($urandom(32'hb8dd));
      rst_n   = 1'b0;
      awvalid = 1'b0;
      awaddr  = '0;
      awid    = '0;
      awlen   = '0;
      awsize  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      arid    = '0;
      arlen   = '0;
      arsize  = '0;
      rready  = 1'b0;
      for (int i = 0; i < 32; i++)
         model[i] = '0;                    // fast registers reset to zero
      repeat (2)
         @(posedge axi);
      rst_n <= 1'b1;

      // fast and slow window data
      for (int i = 0; i < 8; i++) begin
         axi_write("fast_write", fast_base + 32'(4 * i), 4'(i), $urandom,
                   8'd0, size_word, t_aw);
         axi_write("slow_write", slow_base + 32'(4 * i), 4'(i + 8), $urandom,
                   8'd0, size_word, t_aw);
      end
      for (int i = 0; i < 8; i++) begin
         axi_read("fast_read", fast_base + 32'(4 * i), 4'(15 - i), 8'd0, size_word, t_ar);
         axi_read("slow_read", slow_base + 32'(4 * i), 4'(i), 8'd0, size_word, t_ar);
      end
      axi_write("fast_rewrite", fast_base + 32'h8, 4'h3, $urandom, 8'd0, size_word, t_aw);
      axi_read("fast_reread", fast_base + 32'h8, 4'h4, 8'd0, size_word, t_ar);
      axi_write("slow_rewrite", slow_base + 32'hc, 4'h7, $urandom, 8'd0, size_word, t_aw);
      axi_read("slow_reread", slow_base + 32'hc, 4'h9, 8'd0, size_word, t_ar);

      // unmapped window, watchdog ends it
      axi_write("hole_write", hole_base + 32'h10, 4'h5, 32'hdead_beef,
                8'd0, size_word, t_aw);
      axi_read("hole_read", hole_base + 32'h24, 4'h6, 8'd0, size_word, t_ar);

      // refused accesses leave the target untouched
      axi_write("burst_write", fast_base + 32'h4, 4'h1, $urandom, 8'd3, size_word, t_aw);
      axi_write("narrow_write", slow_base + 32'h8, 4'h2, $urandom, 8'd0, 3'd1, t_aw);
      axi_read("burst_read", fast_base + 32'h4, 4'hc, 8'd1, size_word, t_ar);
      axi_read("narrow_read", slow_base + 32'h8, 4'hd, 8'd0, 3'd0, t_ar);
      axi_read("burst_keep", fast_base + 32'h4, 4'he, 8'd0, size_word, t_ar);
      axi_read("narrow_keep", slow_base + 32'h8, 4'hf, 8'd0, size_word, t_ar);

      // write wins when both address channels rise together
      val = $urandom;
      fork
         axi_write("prio_write", fast_base + 32'h3c, 4'ha, val, 8'd0, size_word, t_aw);
         axi_read("prio_read", fast_base + 32'h3c, 4'hb, 8'd0, size_word, t_ar);
      join
      check_equal("prio_order", 32'd1, 32'(t_aw < t_ar));
      axi_read("prio_after", fast_base + 32'h3c, 4'h8, 8'd0, size_word, t_ar);

      repeat (4)
         @(posedge axi);
      if (UUT.u_fsm.u_asserts.failed) begin
         $display("a bound protocol assertion failed");
         abort_run();
      end else begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

//--- files.f
hw/axi_bridge_pkg.sv
hw/sys_bus_if.sv
hw/ack_watchdog.sv
hw/reg_bank.sv
hw/axi_access_fsm.sv
hw/axi_bridge_top.sv
bench/tb_clock.sv
bench/axi_bridge_asserts.sv
bench/tb_axi_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the AXI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f files.f --top-module tb_axi_bridge -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

# a bound assertion raises a flag that the testbench turns into its fail exit
./obj_dir/sim_tb +verilator+error+limit+10 > "$log" 2>&1
sim_status=$?
cat "$log"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "sim passed" "$log"; then
   echo "result: simulation passed"
   exit 0
else
   echo "result: pass line not found in $log"
   exit 1
fi
